//--- Makefile
TOP = tbFuseFront

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- freeCounter.sv
module freeCounter (
    input  logic       clk,
    input  logic       rst,
    input  logic       mispredict,
    input  logic [1:0] wrCount,
    input  logic [1:0] rdCount,
    output logic       full
);

    logic [frontCfgPkg::CNT_W-1:0] freeCnt;
    logic [frontCfgPkg::CNT_W-1:0] nextFree;
    logic [frontCfgPkg::CNT_W-1:0] wrExt;
    logic [frontCfgPkg::CNT_W-1:0] rdExt;

    assign wrExt = {{(frontCfgPkg::CNT_W-2){1'b0}}, wrCount};
    assign rdExt = {{(frontCfgPkg::CNT_W-2){1'b0}}, rdCount};

    // writes and reads of the same edge both count
    assign nextFree = freeCnt - wrExt + rdExt;

    always_ff @(posedge clk) begin
        if (rst || mispredict) begin
            freeCnt <= frontCfgPkg::BUF_SIZE[frontCfgPkg::CNT_W-1:0];
            full    <= 1'b0;
        end else begin
            freeCnt <= nextFree;
            full    <= nextFree < frontCfgPkg::FULL_THRESH[frontCfgPkg::CNT_W-1:0];
        end
    end

endmodule

//--- frontCfgPkg.sv
package frontCfgPkg;

    localparam int NUM_UOPS_IN  = 2; // ops accepted per cycle
    localparam int NUM_UOPS_OUT = 2; // ops handed to rename per cycle
    localparam int BUF_SIZE     = 8;

    // two groups can still be in flight in the fuser when full rises
    localparam int FULL_THRESH  = 4;

    localparam int IDX_W = $clog2(BUF_SIZE);
    localparam int CNT_W = IDX_W + 1; // counts 0 .. BUF_SIZE

    typedef struct packed {
        uopPkg::MicroOp [NUM_UOPS_IN-1:0] uops; // slot 0 oldest
    } InGroup;

    typedef struct packed {
        uopPkg::MicroOp [NUM_UOPS_OUT-1:0] uops; // slot 0 oldest
    } OutGroup;

endpackage

//--- fuseFront.sv
module fuseFront (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mispredict,
    input  logic                 frontEn,
    input  frontCfgPkg::InGroup  inGroup,
    output logic                 full,
    output frontCfgPkg::OutGroup outGroup
);

    frontCfgPkg::InGroup insGroup;
    logic [1:0]          wrCount;
    logic [1:0]          rdCount;
    logic                advance;

    assign advance = !full; // fuser steps only while the queue has room

    uopFuser fuser (
        .clk        (clk),
        .rst        (rst),
        .mispredict (mispredict),
        .advance    (advance),
        .inGroup    (inGroup),
        .insGroup   (insGroup)
    );

    uopQueue queue (
        .clk        (clk),
        .rst        (rst),
        .mispredict (mispredict),
        .advance    (advance),
        .frontEn    (frontEn),
        .insGroup   (insGroup),
        .outGroup   (outGroup),
        .wrCount    (wrCount),
        .rdCount    (rdCount)
    );

    freeCounter counter (
        .clk        (clk),
        .rst        (rst),
        .mispredict (mispredict),
        .wrCount    (wrCount),
        .rdCount    (rdCount),
        .full       (full)
    );

endmodule

//--- fuseFront_props.sv
module fuseFrontProps (
    input logic                               clk,
    input logic                               rst,
    input logic                               mispredict,
    input frontCfgPkg::OutGroup               outGroup,
    input logic [frontCfgPkg::CNT_W-1:0]      freeCnt,
    input logic [frontCfgPkg::IDX_W:0]        used
);

    freeInRange: assert property (@(posedge clk) disable iff (rst)
        freeCnt <= frontCfgPkg::BUF_SIZE)
        else $error("free count above queue depth");

    noOverflow: assert property (@(posedge clk) disable iff (rst)
        used <= frontCfgPkg::BUF_SIZE)
        else $error("queue holds more entries than its depth");

    // slot 1 only valid together with slot 0
    packedValid: assert property (@(posedge clk) disable iff (rst)
        !outGroup.uops[0].valid |-> !outGroup.uops[1].valid)
        else $error("output valid bits not packed from slot 0");

    flushClears: assert property (@(posedge clk) disable iff (rst)
        mispredict |=> !outGroup.uops[0].valid && !outGroup.uops[1].valid)
        else $error("output still valid after mispredict");

endmodule

bind fuseFront fuseFrontProps props (
    .clk        (clk),
    .rst        (rst),
    .mispredict (mispredict),
    .outGroup   (outGroup),
    .freeCnt    (counter.freeCnt),
    .used       (queue.used)
);

//--- sim.f
uopPkg.sv
frontCfgPkg.sv
uopFuser.sv
freeCounter.sv
uopQueue.sv
fuseFront.sv
fuseFront_props.sv
tbFuseFront.sv

//--- tbFuseFront.sv
module tbFuseFront;

    typedef uopPkg::MicroOp UopList[$];

    localparam int STIM_CYCLES = 180; // all phases incl. drains
    localparam int LIMIT       = 4 * STIM_CYCLES + 50;

    logic                 clk;
    logic                 rst;
    logic                 mispredict;
    logic                 frontEn;
    logic                 full;
    frontCfgPkg::InGroup  inGroup;
    frontCfgPkg::OutGroup outGroup;

    integer  seed = 32'hec779f9f;
    int      cycles = 0;
    int      errCount = 0;
    int      obsCount = 0;
    bit      flushCheck = 0;
    UopList  stream; // every accepted slot, invalid ones too

    frontCfgPkg::InGroup idleGroup = '0;
    frontCfgPkg::InGroup g;

    fuseFront UUT (
        .clk        (clk),
        .rst        (rst),
        .mispredict (mispredict),
        .frontEn    (frontEn),
        .inGroup    (inGroup),
        .full       (full),
        .outGroup   (outGroup)
    );

    always #4 clk = ~clk;

    function automatic uopPkg::MicroOp makeUop(
        input uopPkg::FuncUnit fu,
        input uopPkg::IntOp    op,
        input logic [4:0]      rd,
        input logic [4:0]      rs0,
        input logic            immB,
        input logic [31:0]     imm
    );
        uopPkg::MicroOp u;
        u.valid  = 1'b1;
        u.fu     = fu;
        u.opcode = op;
        u.rd     = rd;
        u.rs0    = rs0;
        u.rs1    = rd + 5'd1;
        u.immB   = immB;
        u.imm    = imm;
        u.pcLow  = imm[9:0] ^ {rd, rs0};
        return u;
    endfunction

    // upper-immediate op, then addi writing and reading the same rd
    function automatic logic pairFuses(input uopPkg::MicroOp a, input uopPkg::MicroOp b);
        logic upper;
        logic addi;
        upper = a.fu == uopPkg::FU_INT &&
                (a.opcode == uopPkg::INT_LUI || a.opcode == uopPkg::INT_AUIPC);
        addi  = b.fu == uopPkg::FU_INT && b.opcode == uopPkg::INT_ADD && b.immB;
        return a.valid && b.valid && upper && addi && b.rs0 == b.rd && a.rd == b.rd;
    endfunction

    function automatic UopList refModel(input UopList s);
        UopList         res;
        bit             eaten [];
        uopPkg::MicroOp u;
        eaten = new[s.size() + 1];
        for (int i = 0; i < s.size(); i++) begin
            if (!eaten[i] && s[i].valid) begin
                u = s[i];
                if (i + 1 < s.size() && pairFuses(s[i], s[i+1])) begin
                    u.imm = {s[i].imm[31:12], 12'h000} + 32'($signed(s[i+1].imm[11:0]));
                    eaten[i+1] = 1'b1;
                end
                res.push_back(u);
            end
        end
        return res;
    endfunction

    task automatic reportError(input string msg);
        errCount++;
        $display("[ERROR] %0t: %s", $time, msg);
        $display("sim failed");
        $fatal(1, "check failed");
    endtask

    task automatic checkUop(input uopPkg::MicroOp got, input uopPkg::MicroOp exp);
        if (got !== exp) begin
            reportError($sformatf("op %0d got %h expected %h", obsCount, got, exp));
        end
    endtask

    task automatic checkFull(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            reportError($sformatf("%s: full is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic checkIdle(input frontCfgPkg::OutGroup got);
        if (got.uops[0].valid !== 1'b0 || got.uops[1].valid !== 1'b0) begin
            reportError("output valid after reset or flush");
        end
    endtask

    task automatic randGroup(input bit biased, output frontCfgPkg::InGroup grp);
        int          pick;
        logic [4:0]  rd;
        logic [31:0] imm;
        for (int i = 0; i < frontCfgPkg::NUM_UOPS_IN; i++) begin
            pick = $unsigned($random(seed)) % 8;
            imm  = $random(seed);
            if (biased) begin
                rd = 5'd1 + 5'($unsigned($random(seed)) % 2); // small rd range
                case (pick)
                    0, 1, 2: grp.uops[i] = makeUop(uopPkg::FU_INT, uopPkg::INT_LUI, rd, 5'd0,
                                                   1'b1, imm);
                    3:       grp.uops[i] = makeUop(uopPkg::FU_INT, uopPkg::INT_AUIPC, rd,
                                                   5'd0, 1'b1, imm);
                    4, 5:    grp.uops[i] = makeUop(uopPkg::FU_INT, uopPkg::INT_ADD, rd, rd,
                                                   1'b1, imm);
                    6:       grp.uops[i] = makeUop(uopPkg::FU_INT, uopPkg::INT_ADD, rd, rd,
                                                   imm[31], imm);
                    default: grp.uops[i] = makeUop(uopPkg::FU_INT, uopPkg::INT_SUB, rd,
                                                   rd + 5'd2, 1'b0, imm);
                endcase
            end else begin
                rd = 5'($unsigned($random(seed)) % 32);
                case (pick % 4)
                    0:       grp.uops[i] = makeUop(uopPkg::FU_INT, uopPkg::INT_SUB, rd, rd,
                                                   1'b0, imm);
                    1:       grp.uops[i] = makeUop(uopPkg::FU_INT, uopPkg::INT_AND, rd, rd,
                                                   1'b1, imm);
                    2:       grp.uops[i] = makeUop(uopPkg::FU_INT, uopPkg::INT_OR, rd, rd,
                                                   1'b1, imm);
                    default: grp.uops[i] = makeUop(uopPkg::FU_LSU, uopPkg::INT_ADD, rd, rd,
                                                   1'b1, imm);
                endcase
            end
            grp.uops[i].valid = ($unsigned($random(seed)) % 8) != 0;
        end
    endtask

    // holds the group until the edge that takes it
    task automatic sendGroup(input frontCfgPkg::InGroup grp);
        inGroup <= grp;
        @(posedge clk);
        while (full) begin
            @(posedge clk);
        end
    endtask

    task automatic sendPair(input uopPkg::MicroOp a, input uopPkg::MicroOp b);
        frontCfgPkg::InGroup grp;
        grp.uops[0] = a;
        grp.uops[1] = b;
        sendGroup(grp);
    endtask

    // consumer off until full rises, grp is the group still waiting
    task automatic fillQueue(output frontCfgPkg::InGroup grp);
        frontEn <= 1'b0;
        randGroup(1'b1, grp);
        for (int k = 0; k < 12; k++) begin
            inGroup <= grp;
            @(posedge clk);
            if (!full) begin
                randGroup(1'b1, grp); // taken, move on
            end
        end
        checkFull(full, 1'b1, "queue held back");
    endtask

    task automatic drain();
        UopList exp;
        do begin
            sendGroup(idleGroup);
            exp = refModel(stream);
        end while (obsCount < exp.size());
    endtask

    // record what the DUT accepts at this edge
    always @(posedge clk) begin
        if (rst || mispredict) begin
            stream.delete();
            obsCount   = 0;
            flushCheck = 1;
        end else if (!full) begin
            for (int i = 0; i < frontCfgPkg::NUM_UOPS_IN; i++) begin
                stream.push_back(inGroup.uops[i]);
            end
        end
    end

    always @(negedge clk) begin
        UopList exp;
        if (flushCheck) begin
            checkIdle(outGroup);
            checkFull(full, 1'b0, "after reset or flush");
            flushCheck = 0;
        end
        for (int i = 0; i < frontCfgPkg::NUM_UOPS_OUT; i++) begin
            if (outGroup.uops[i].valid === 1'b1) begin
                exp = refModel(stream);
                if (obsCount >= exp.size()) begin
                    reportError("op delivered that was never expected");
                end else begin
                    checkUop(outGroup.uops[i], exp[obsCount]);
                end
                obsCount++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("run timed out after %0d cycles", cycles);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        mispredict = 1'b0;
        frontEn    = 1'b1;
        inGroup    = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // plain ops pass unchanged
        for (int k = 0; k < 16; k++) begin
            randGroup(1'b0, g);
            sendGroup(g);
        end
        drain();

        // pairs inside one group
        sendPair(makeUop(uopPkg::FU_INT, uopPkg::INT_LUI, 5'd5, 5'd0, 1'b1, 32'h12345000),
                 makeUop(uopPkg::FU_INT, uopPkg::INT_ADD, 5'd5, 5'd5, 1'b1, 32'h00000678));
        sendPair(makeUop(uopPkg::FU_INT, uopPkg::INT_AUIPC, 5'd7, 5'd0, 1'b1, 32'habcde000),
                 makeUop(uopPkg::FU_INT, uopPkg::INT_ADD, 5'd7, 5'd7, 1'b1, 32'hffffffff));
        drain();

        // split pair, then the same split with an idle cycle between
        sendPair(makeUop(uopPkg::FU_INT, uopPkg::INT_SUB, 5'd2, 5'd3, 1'b0, 32'h0),
                 makeUop(uopPkg::FU_INT, uopPkg::INT_LUI, 5'd3, 5'd0, 1'b1, 32'h80000000));
        sendPair(makeUop(uopPkg::FU_INT, uopPkg::INT_ADD, 5'd3, 5'd3, 1'b1, 32'h00000810),
                 makeUop(uopPkg::FU_INT, uopPkg::INT_OR, 5'd4, 5'd4, 1'b1, 32'h55));
        sendPair(makeUop(uopPkg::FU_INT, uopPkg::INT_AND, 5'd1, 5'd1, 1'b1, 32'h7),
                 makeUop(uopPkg::FU_INT, uopPkg::INT_LUI, 5'd4, 5'd0, 1'b1, 32'h00042000));
        sendGroup(idleGroup);
        sendPair(makeUop(uopPkg::FU_INT, uopPkg::INT_ADD, 5'd4, 5'd4, 1'b1, 32'h00000123),
                 makeUop(uopPkg::FU_INT, uopPkg::INT_SUB, 5'd6, 5'd6, 1'b0, 32'h0));
        drain();

        // rule breakers and a chain
        sendPair(makeUop(uopPkg::FU_INT, uopPkg::INT_LUI, 5'd6, 5'd0, 1'b1, 32'h11111000),
                 makeUop(uopPkg::FU_INT, uopPkg::INT_ADD, 5'd8, 5'd8, 1'b1, 32'h00000001));
        sendPair(makeUop(uopPkg::FU_INT, uopPkg::INT_LUI, 5'd6, 5'd0, 1'b1, 32'h22222000),
                 makeUop(uopPkg::FU_INT, uopPkg::INT_ADD, 5'd6, 5'd6, 1'b0, 32'h00000002));
        sendPair(makeUop(uopPkg::FU_INT, uopPkg::INT_LUI, 5'd6, 5'd0, 1'b1, 32'h33333000),
                 makeUop(uopPkg::FU_INT, uopPkg::INT_ADD, 5'd6, 5'd2, 1'b1, 32'h00000003));
        sendPair(makeUop(uopPkg::FU_INT, uopPkg::INT_LUI, 5'd9, 5'd0, 1'b1, 32'h44444000),
                 makeUop(uopPkg::FU_INT, uopPkg::INT_ADD, 5'd9, 5'd9, 1'b1, 32'h00000004));
        sendPair(makeUop(uopPkg::FU_INT, uopPkg::INT_ADD, 5'd9, 5'd9, 1'b1, 32'h00000005),
                 makeUop(uopPkg::FU_INT, uopPkg::INT_SUB, 5'd9, 5'd1, 1'b0, 32'h0));
        drain();

        // random mix with many fusions
        for (int k = 0; k < 24; k++) begin
            randGroup(1'b1, g);
            sendGroup(g);
        end
        drain();

        // back-pressure
        fillQueue(g);
        frontEn <= 1'b1;
        sendGroup(g);
        drain();

        // flush while the queue is held full and the consumer comes back
        fillQueue(g);
        mispredict <= 1'b1;
        frontEn    <= 1'b1;
        inGroup    <= idleGroup;
        @(posedge clk);
        mispredict <= 1'b0;
        for (int k = 0; k < 6; k++) begin
            randGroup(1'b1, g);
            sendGroup(g);
        end
        drain();

        repeat (4) @(posedge clk);
        if (errCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- uopFuser.sv
module uopFuser (
    input  logic                clk,
    input  logic                rst,
    input  logic                mispredict,
    input  logic                advance,
    input  frontCfgPkg::InGroup inGroup,
    output frontCfgPkg::InGroup insGroup
);

    frontCfgPkg::InGroup stageOne;
    frontCfgPkg::InGroup fusedGroup; // stage one after fusion
    frontCfgPkg::InGroup nextGroup;  // incoming group, slot 0 may be consumed

    // stage one ops plus incoming slot 0
    uopPkg::MicroOp window [frontCfgPkg::NUM_UOPS_IN+1];
    logic [frontCfgPkg::NUM_UOPS_IN:0] eaten; // window op absorbed by its predecessor

    // lui/auipc rd, X followed by addi rd, rd, Y
    function automatic logic canFuse(
        input uopPkg::MicroOp first,
        input uopPkg::MicroOp second
    );
        logic upperOp;
        logic addImm;
        upperOp = first.fu == uopPkg::FU_INT &&
                  (first.opcode == uopPkg::INT_LUI || first.opcode == uopPkg::INT_AUIPC);
        addImm  = second.fu == uopPkg::FU_INT && second.opcode == uopPkg::INT_ADD &&
                  second.immB;
        return first.valid && second.valid && upperOp && addImm &&
               second.rs0 == second.rd && first.rd == second.rd;
    endfunction

    function automatic logic [31:0] fuseImm(
        input uopPkg::MicroOp first,
        input uopPkg::MicroOp second
    );
        logic [31:0] upper;
        logic [31:0] lower;
        upper = {first.imm[31:12], 12'b0};
        lower = {{20{second.imm[11]}}, second.imm[11:0]}; // sign extended
        return upper + lower;
    endfunction

    always_comb begin
        for (int i = 0; i < frontCfgPkg::NUM_UOPS_IN; i++) begin
            window[i] = stageOne.uops[i];
        end
        window[frontCfgPkg::NUM_UOPS_IN] = inGroup.uops[0];
    end

    always_comb begin
        fusedGroup = stageOne; // pass through by default
        nextGroup  = inGroup;
        eaten      = '0;

        // walk adjacent pairs oldest first so a consumed op never starts a pair
        for (int i = 0; i < frontCfgPkg::NUM_UOPS_IN; i++) begin
            if (!eaten[i] && canFuse(window[i], window[i+1])) begin
                fusedGroup.uops[i].imm = fuseImm(window[i], window[i+1]);
                eaten[i+1] = 1'b1;
            end
        end

        for (int i = 0; i < frontCfgPkg::NUM_UOPS_IN; i++) begin
            if (eaten[i]) begin
                fusedGroup.uops[i].valid = 1'b0;
            end
        end
        // the add of a cross-group pair never enters stage one
        if (eaten[frontCfgPkg::NUM_UOPS_IN]) begin
            nextGroup.uops[0].valid = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || mispredict) begin
            for (int i = 0; i < frontCfgPkg::NUM_UOPS_IN; i++) begin
                stageOne.uops[i].valid <= 1'b0;
                insGroup.uops[i].valid <= 1'b0;
            end
        end else if (advance) begin
            stageOne <= nextGroup;
            insGroup <= fusedGroup; // stage two
        end
    end

endmodule

//--- uopPkg.sv
package uopPkg;

    // functional unit that executes the op
    typedef enum logic [1:0] {
        FU_INT    = 2'd0,
        FU_LSU    = 2'd1,
        FU_BRANCH = 2'd2,
        FU_MUL    = 2'd3
    } FuncUnit;

    // integer unit opcodes
    typedef enum logic [3:0] {
        INT_ADD   = 4'd0,
        INT_LUI   = 4'd1, // imm[31:12] holds the upper immediate
        INT_AUIPC = 4'd2,
        INT_SUB   = 4'd3,
        INT_AND   = 4'd4,
        INT_OR    = 4'd5
    } IntOp;

    // Decoded micro-op as it leaves the decoder. A fused LUI/AUIPC keeps its
    // own opcode and carries the full 32 bit constant in imm.
    typedef struct packed {
        logic       valid;
        FuncUnit    fu;
        IntOp       opcode;
        logic [4:0] rd;
        logic [4:0] rs0;
        logic [4:0] rs1;
        logic       immB;  // second operand is imm, not rs1
        logic [31:0] imm;
        logic [9:0] pcLow; // low pc bits for debug
    } MicroOp;

endpackage

//--- uopQueue.sv
module uopQueue (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mispredict,
    input  logic                 advance,
    input  logic                 frontEn,
    input  frontCfgPkg::InGroup  insGroup,
    output frontCfgPkg::OutGroup outGroup,
    output logic [1:0]           wrCount,
    output logic [1:0]           rdCount
);

    uopPkg::MicroOp buffer [frontCfgPkg::BUF_SIZE];

    logic [frontCfgPkg::IDX_W:0]   wrPtr; // msb is the wrap bit
    logic [frontCfgPkg::IDX_W:0]   rdPtr;
    logic [frontCfgPkg::IDX_W:0]   used;
    logic [frontCfgPkg::IDX_W-1:0] wrIdx [frontCfgPkg::NUM_UOPS_IN];
    logic [frontCfgPkg::IDX_W-1:0] rdIdx [frontCfgPkg::NUM_UOPS_OUT];
    logic [frontCfgPkg::NUM_UOPS_IN-1:0]  wrEn;
    logic [frontCfgPkg::NUM_UOPS_OUT-1:0] rdEn;

    assign used = wrPtr - rdPtr;

    // valid slots go to consecutive entries
    always_comb begin
        logic [frontCfgPkg::IDX_W-1:0] off;
        off = '0;
        for (int i = 0; i < frontCfgPkg::NUM_UOPS_IN; i++) begin
            wrEn[i]  = advance && insGroup.uops[i].valid;
            wrIdx[i] = wrPtr[frontCfgPkg::IDX_W-1:0] + off;
            if (wrEn[i]) begin
                off = off + 1'b1;
            end
        end
        wrCount = off[1:0];
    end

    // only entries written before this edge can leave
    always_comb begin
        logic [frontCfgPkg::IDX_W:0]   left;
        logic [frontCfgPkg::IDX_W-1:0] off;
        left = used;
        off  = '0;
        for (int i = 0; i < frontCfgPkg::NUM_UOPS_OUT; i++) begin
            rdEn[i]  = frontEn && left != '0;
            rdIdx[i] = rdPtr[frontCfgPkg::IDX_W-1:0] + off;
            if (rdEn[i]) begin
                left = left - 1'b1;
                off  = off + 1'b1;
            end
        end
        rdCount = off[1:0];
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < frontCfgPkg::NUM_UOPS_IN; i++) begin
            if (wrEn[i]) begin
                buffer[wrIdx[i]] <= insGroup.uops[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || mispredict) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            wrPtr <= wrPtr + {{(frontCfgPkg::IDX_W-1){1'b0}}, wrCount};
            rdPtr <= rdPtr + {{(frontCfgPkg::IDX_W-1){1'b0}}, rdCount};
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < frontCfgPkg::NUM_UOPS_OUT; i++) begin
            outGroup.uops[i] <= buffer[rdIdx[i]];
            if (rst || mispredict) begin
                outGroup.uops[i].valid <= 1'b0;
            end else begin
                outGroup.uops[i].valid <= rdEn[i]; // one cycle per delivered op
            end
        end
    end

endmodule
